/* bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_ifu.sv
  - src/rv_regfile.sv
  - src/rv_decoder.sv
  - src/rv_exu.sv
  - src/rv_lsu.sv
  - src/rv_wbu.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/rv_core_tb.sv

/* dv/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

	localparam int max_rows = 32;
	localparam int timeout_cycles = 200;
	localparam logic [31:0] ebreak_word = 32'h0010_0073;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_load = 7'b0000011;

	logic clk;
	logic reset_i;
	logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata, pc;
	logic dmem_wen, finish, invalid;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:255];
	logic [31:0] lfsr_q;

	// one row per program with its expected outcome
	string row_name [max_rows];
	logic [31:0] row_prog [max_rows][8];
	int row_stores [max_rows];
	logic [31:0] row_addr [max_rows];
	logic [31:0] row_data [max_rows];
	logic row_invalid [max_rows];
	int n_rows;
	int n_inst;

	tb_clock #(.PERIOD(20)) u_clock (.clk_o(clk));

	rv_core_top #(
		.RESET_PC(32'h0)
	) dut (
		.clk(clk), .reset_i(reset_i),
		.imem_addr_o(imem_addr), .imem_data_i(imem_data),
		.dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
		.dmem_wen_o(dmem_wen), .dmem_rdata_i(dmem_rdata),
		.pc_o(pc), .finish_o(finish), .invalid_o(invalid)
	);

	// both memories answer in the same cycle
	assign imem_data = imem[imem_addr[7:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_wen) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// sw only
	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic fill_dmem();
		logic [31:0] w;
		for (int i = 0; i < 256; i++) begin
			w = 32'h0;
			for (int b = 0; b < 32; b++) begin
				lfsr_q = lfsr_step(lfsr_q);
				w = {w[30:0], lfsr_q[0]};
			end
			dmem[i] = w;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s (%s): expected %h, actual %h", name, what, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic start_row(input string name);
		row_name[n_rows] = name;
		n_inst = 0;
		// unused slots decode as invalid
		for (int i = 0; i < 8; i++) begin
			row_prog[n_rows][i] = 32'h0;
		end
	endtask

	task automatic add_inst(input logic [31:0] inst);
		row_prog[n_rows][n_inst] = inst;
		n_inst++;
	endtask

	task automatic close_row(input int stores, input logic [31:0] addr,
		input logic [31:0] data, input logic inv);
		row_stores[n_rows] = stores;
		row_addr[n_rows] = addr;
		row_data[n_rows] = data;
		row_invalid[n_rows] = inv;
		n_rows++;
	endtask

	// x1 = 0x12345678, x2 = -3, result in x3 goes to 0x100
	task automatic alu_row(input string name, input logic [31:0] inst, input logic [31:0] exp);
		start_row(name);
		add_inst(utype(20'h12345, 1, op_lui));
		add_inst(itype(12'h678, 1, 3'b000, 1, op_imm));
		add_inst(itype(-3, 0, 3'b000, 2, op_imm));
		add_inst(inst);
		add_inst(stype(12'h100, 3, 0));
		add_inst(ebreak_word);
		close_row(1, 32'h100, exp, 1'b0);
	endtask

	// first branch must fall through, second must skip the store of x1
	task automatic branch_row(input string name, input logic [2:0] f3,
		input logic [4:0] nt1, input logic [4:0] nt2, input logic [4:0] t1,
		input logic [4:0] t2, input logic [11:0] marker);
		start_row(name);
		add_inst(itype(-1, 0, 3'b000, 1, op_imm));
		add_inst(itype(1, 0, 3'b000, 2, op_imm));
		add_inst(itype(marker, 0, 3'b000, 3, op_imm));
		add_inst(btype(16, nt2, nt1, f3));
		add_inst(btype(8, t2, t1, f3));
		add_inst(stype(12'h100, 1, 0));
		add_inst(stype(12'h104, 3, 0));
		add_inst(ebreak_word);
		close_row(1, 32'h104, {20'h0, marker}, 1'b0);
	endtask

	task automatic build_table();
		alu_row("addi", itype(-16, 1, 3'b000, 3, op_imm), 32'h1234_5668);
		alu_row("add", rtype(7'h00, 2, 1, 3'b000, 3), 32'h1234_5675);
		alu_row("sub", rtype(7'h20, 2, 1, 3'b000, 3), 32'h1234_567b);
		alu_row("slt", rtype(7'h00, 1, 2, 3'b010, 3), 32'h1);
		alu_row("sltu", rtype(7'h00, 1, 2, 3'b011, 3), 32'h0);
		alu_row("xor", rtype(7'h00, 2, 1, 3'b100, 3), 32'hedcb_a985);
		alu_row("or", rtype(7'h00, 2, 1, 3'b110, 3), 32'hffff_fffd);
		alu_row("and", rtype(7'h00, 2, 1, 3'b111, 3), 32'h1234_5678);
		alu_row("slli", itype(12'h004, 1, 3'b001, 3, op_imm), 32'h2345_6780);
		alu_row("sll", rtype(7'h00, 1, 1, 3'b001, 3), 32'h7800_0000);
		alu_row("srl", rtype(7'h00, 1, 2, 3'b101, 3), 32'h0000_00ff);
		alu_row("sra", rtype(7'h20, 1, 2, 3'b101, 3), 32'hffff_ffff);
		alu_row("srai", itype(12'h401, 2, 3'b101, 3, op_imm), 32'hffff_fffe);
		alu_row("lui", utype(20'habcde, 3, op_lui), 32'habcd_e000);
		// auipc sits at address 12
		alu_row("auipc", utype(20'h00001, 3, op_auipc), 32'h0000_100c);
		branch_row("beq", 3'b000, 1, 2, 1, 1, 12'h011);
		branch_row("bne", 3'b001, 1, 1, 1, 2, 12'h022);
		branch_row("blt", 3'b100, 2, 1, 1, 2, 12'h033);
		branch_row("bge", 3'b101, 1, 2, 2, 1, 12'h044);
		branch_row("bltu", 3'b110, 1, 2, 2, 1, 12'h055);
		branch_row("bgeu", 3'b111, 2, 1, 1, 2, 12'h066);
		start_row("jal");
		add_inst(jtype(12, 5));
		add_inst(stype(12'h100, 0, 0));
		add_inst(ebreak_word);
		add_inst(stype(12'h104, 5, 0));
		add_inst(ebreak_word);
		close_row(1, 32'h104, 32'h4, 1'b0);
		// 17 + 4 gives 21 and the target lands on 20 once bit 0 is cleared
		start_row("jalr");
		add_inst(itype(17, 0, 3'b000, 6, op_imm));
		add_inst(itype(4, 6, 3'b000, 7, op_jalr));
		add_inst(stype(12'h100, 0, 0));
		add_inst(ebreak_word);
		add_inst(ebreak_word);
		add_inst(stype(12'h104, 7, 0));
		add_inst(ebreak_word);
		close_row(1, 32'h104, 32'h8, 1'b0);
		start_row("lw");
		add_inst(itype(12'h040, 0, 3'b010, 1, op_load));
		add_inst(itype(12'h123, 1, 3'b000, 1, op_imm));
		add_inst(stype(12'h104, 1, 0));
		add_inst(ebreak_word);
		close_row(1, 32'h104, dmem[16] + 32'h123, 1'b0);
		start_row("ebreak");
		add_inst(itype(1, 0, 3'b000, 1, op_imm));
		add_inst(ebreak_word);
		close_row(0, 32'h0, 32'h0, 1'b0);
		start_row("zero word");
		add_inst(itype(1, 0, 3'b000, 1, op_imm));
		add_inst(32'h0);
		close_row(0, 32'h0, 32'h0, 1'b1);
	endtask

	task automatic run_row(input int r);
		string name;
		int cycles;
		int since_pc;
		int stores;
		logic [31:0] last_pc, st_addr, st_data;
		logic prev_wen;
		name = row_name[r];
		for (int i = 0; i < 64; i++) begin
			imem[i] = (i < 8) ? row_prog[r][i] : 32'h0;
		end
		@(posedge clk);
		reset_i <= 1'b1;
		repeat (2) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_equal(name, "pc after reset", 32'h0, pc);
		check_equal(name, "flags after reset", 32'h0, {finish, invalid});
		last_pc = pc;
		since_pc = 0;
		cycles = 0;
		stores = 0;
		prev_wen = 1'b0;
		while (!(finish || invalid)) begin
			if (cycles == timeout_cycles) begin
				abort_run($sformatf("%s: no finish or invalid flag within %0d cycles",
					name, timeout_cycles));
			end
			@(negedge clk);
			cycles++;
			since_pc++;
			// fetch address stays word aligned
			check_equal(name, "fetch alignment", 32'h0, {30'h0, imem_addr[1:0]});
			if (pc !== last_pc) begin
				check_equal(name, "cycles per instruction", 32'd5, since_pc);
				since_pc = 0;
				last_pc = pc;
			end
			if (dmem_wen) begin
				if (prev_wen) begin
					abort_run($sformatf("%s: store strobe high for more than one cycle", name));
				end
				check_equal(name, "store cycle", 32'd3, since_pc);
				if (stores == 0) begin
					st_addr = dmem_addr;
					st_data = dmem_wdata;
				end
				stores++;
			end
			prev_wen = dmem_wen;
		end
		check_equal(name, "store count", row_stores[r], stores);
		if (row_stores[r] > 0) begin
			check_equal(name, "store address", row_addr[r], st_addr);
			check_equal(name, "store data", row_data[r], st_data);
		end
		check_equal(name, "finish flag", !row_invalid[r], finish);
		check_equal(name, "invalid flag", row_invalid[r], invalid);
		// core must stay stopped
		repeat (20) begin
			@(negedge clk);
			check_equal(name, "frozen pc", last_pc, pc);
			if (dmem_wen) begin
				abort_run($sformatf("%s: store seen after the core stopped", name));
			end
		end
	endtask

	initial begin
		reset_i = 1'b1;
		lfsr_q = 32'd77;
		n_rows = 0;
		n_inst = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'h0;
		end
		fill_dmem();
		build_table();
		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* rv_core_top.f */
src/rv_pkg.sv
src/rv_ifu.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_exu.sv
src/rv_lsu.sv
src/rv_wbu.sv
src/rv_core_top.sv
dv/tb_clock.sv
dv/rv_core_tb.sv

/* src/rv_core_top.sv */
`default_nettype none

module rv_core_top import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0
) (
	input wire logic clk,
	input wire logic reset_i,
	output word_t imem_addr_o,
	input wire word_t imem_data_i,
	output word_t dmem_addr_o,
	output word_t dmem_wdata_o,
	output logic dmem_wen_o,
	input wire word_t dmem_rdata_i,
	output word_t pc_o,
	output logic finish_o,
	output logic invalid_o
);

	// fetch and register file
	word_t if_inst;
	logic if_valid;
	logic retire, redirect, halt;
	word_t redirect_pc;
	reg_addr_t rf_raddr1, rf_raddr2, rf_waddr;
	word_t rf_rdata1, rf_rdata2, rf_wdata;
	logic rf_wen;

	// decode to execute
	logic id_valid, id_use_imm, id_load, id_store, id_wen, id_ebreak, id_invalid;
	word_t id_pc, id_op_a, id_op_b, id_imm;
	alu_op_e id_alu_op;
	br_op_e id_br_op;
	reg_addr_t id_rd;

	// execute to memory, memory to write-back
	logic ex_valid, ex_load, ex_store, ex_wen, ex_ebreak, ex_invalid;
	word_t ex_result, ex_store_data;
	reg_addr_t ex_rd;
	logic ls_valid, ls_wen, ls_ebreak, ls_invalid;
	word_t ls_wdata;
	reg_addr_t ls_rd;

	rv_ifu #(
		.RESET_PC(RESET_PC)
	) u_ifu (
		.clk(clk), .reset_i(reset_i),
		.imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
		.retire_i(retire), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.halt_i(halt), .pc_o(pc_o), .inst_o(if_inst), .if_valid_o(if_valid)
	);

	rv_regfile u_regfile (
		.clk(clk), .reset_i(reset_i),
		.raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
		.wen_i(rf_wen), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
	);

	rv_decoder u_decoder (
		.clk(clk), .reset_i(reset_i), .if_valid_i(if_valid),
		.inst_i(if_inst), .pc_i(pc_o), .rdata1_i(rf_rdata1), .rdata2_i(rf_rdata2),
		.raddr1_o(rf_raddr1), .raddr2_o(rf_raddr2), .id_valid_o(id_valid),
		.pc_o(id_pc), .op_a_o(id_op_a), .op_b_o(id_op_b), .imm_o(id_imm),
		.use_imm_o(id_use_imm), .alu_op_o(id_alu_op), .br_op_o(id_br_op),
		.load_o(id_load), .store_o(id_store), .wen_o(id_wen), .rd_o(id_rd),
		.ebreak_o(id_ebreak), .invalid_o(id_invalid)
	);

	rv_exu u_exu (
		.clk(clk), .reset_i(reset_i), .id_valid_i(id_valid),
		.pc_i(id_pc), .op_a_i(id_op_a), .op_b_i(id_op_b), .imm_i(id_imm),
		.use_imm_i(id_use_imm), .alu_op_i(id_alu_op), .br_op_i(id_br_op),
		.load_i(id_load), .store_i(id_store), .wen_i(id_wen), .rd_i(id_rd),
		.ebreak_i(id_ebreak), .invalid_i(id_invalid),
		.ex_valid_o(ex_valid), .result_o(ex_result), .store_data_o(ex_store_data),
		.load_o(ex_load), .store_o(ex_store), .wen_o(ex_wen), .rd_o(ex_rd),
		.ebreak_o(ex_ebreak), .invalid_o(ex_invalid),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc)
	);

	rv_lsu u_lsu (
		.clk(clk), .reset_i(reset_i), .ex_valid_i(ex_valid),
		.result_i(ex_result), .store_data_i(ex_store_data),
		.load_i(ex_load), .store_i(ex_store), .wen_i(ex_wen), .rd_i(ex_rd),
		.ebreak_i(ex_ebreak), .invalid_i(ex_invalid),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
		.dmem_wen_o(dmem_wen_o), .dmem_rdata_i(dmem_rdata_i),
		.ls_valid_o(ls_valid), .wdata_o(ls_wdata), .wen_o(ls_wen), .rd_o(ls_rd),
		.ebreak_o(ls_ebreak), .invalid_o(ls_invalid)
	);

	rv_wbu u_wbu (
		.clk(clk), .reset_i(reset_i), .ls_valid_i(ls_valid),
		.wdata_i(ls_wdata), .wen_i(ls_wen), .rd_i(ls_rd),
		.ebreak_i(ls_ebreak), .invalid_i(ls_invalid),
		.reg_wen_o(rf_wen), .reg_waddr_o(rf_waddr), .reg_wdata_o(rf_wdata),
		.retire_o(retire), .finish_o(finish_o), .invalid_o(invalid_o),
		.halt_o(halt)
	);

endmodule

`default_nettype wire

/* src/rv_decoder.sv */
`default_nettype none

module rv_decoder import rv_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic if_valid_i,
	input wire word_t inst_i,
	input wire word_t pc_i,
	input wire word_t rdata1_i,
	input wire word_t rdata2_i,
	output reg_addr_t raddr1_o,
	output reg_addr_t raddr2_o,
	output logic id_valid_o,
	output word_t pc_o,
	output word_t op_a_o,
	output word_t op_b_o,
	output word_t imm_o,
	output logic use_imm_o,
	output alu_op_e alu_op_o,
	output br_op_e br_op_o,
	output logic load_o,
	output logic store_o,
	output logic wen_o,
	output reg_addr_t rd_o,
	output logic ebreak_o,
	output logic invalid_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i_ty, imm_s_ty, imm_b_ty, imm_u_ty, imm_j_ty;
	word_t imm;
	logic use_imm, sel_pc, load, store, wen, ebreak, invalid;
	alu_op_e alu_op;
	br_op_e br_op;

	// funct3 to alu op, alt picks sub or sra
	function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	assign imm_i_ty = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_ty = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_ty = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_u_ty = {inst_i[31:12], 12'b0};
	assign imm_j_ty = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	always_comb begin
		imm = imm_i_ty;
		use_imm = 1'b0;
		sel_pc = 1'b0;
		alu_op = alu_add;
		br_op = br_none;
		load = 1'b0;
		store = 1'b0;
		wen = 1'b0;
		ebreak = 1'b0;
		invalid = 1'b0;
		case (opcode)
			op_lui: begin
				imm = imm_u_ty;
				use_imm = 1'b1;
				alu_op = alu_pass_b;
				wen = 1'b1;
			end
			op_auipc: begin
				imm = imm_u_ty;
				use_imm = 1'b1;
				sel_pc = 1'b1;
				wen = 1'b1;
			end
			op_jal: begin
				imm = imm_j_ty;
				br_op = br_jal;
				wen = 1'b1;
			end
			op_jalr: begin
				br_op = br_jalr;
				wen = 1'b1;
				invalid = (funct3 != 3'b000);
			end
			op_branch: begin
				imm = imm_b_ty;
				case (funct3)
					3'b000: br_op = br_eq;
					3'b001: br_op = br_ne;
					3'b100: br_op = br_lt;
					3'b101: br_op = br_ge;
					3'b110: br_op = br_ltu;
					3'b111: br_op = br_geu;
					default: invalid = 1'b1;
				endcase
			end
			op_load: begin
				use_imm = 1'b1;
				load = 1'b1;
				wen = 1'b1;
				// word access only
				invalid = (funct3 != 3'b010);
			end
			op_store: begin
				imm = imm_s_ty;
				use_imm = 1'b1;
				store = 1'b1;
				invalid = (funct3 != 3'b010);
			end
			op_imm: begin
				use_imm = 1'b1;
				wen = 1'b1;
				alu_op = alu_from_f3(funct3, funct3 == 3'b101 && inst_i[30]);
				if (funct3 == 3'b001 && funct7 != 7'b0) begin
					invalid = 1'b1;
				end
				if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0) begin
					invalid = 1'b1;
				end
			end
			op_reg: begin
				wen = 1'b1;
				alu_op = alu_from_f3(funct3, inst_i[30]);
				if ((funct7 & 7'b1011111) != 7'b0) begin
					invalid = 1'b1;
				end
				if (inst_i[30] && funct3 != 3'b000 && funct3 != 3'b101) begin
					invalid = 1'b1;
				end
			end
			op_system: begin
				ebreak = (inst_i == 32'h0010_0073);
				invalid = !ebreak;
			end
			default: invalid = 1'b1;
		endcase
		// bad encodings must not touch state
		if (invalid) begin
			wen = 1'b0;
			load = 1'b0;
			store = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			id_valid_o <= 1'b0;
			br_op_o <= br_none;
			load_o <= 1'b0;
			store_o <= 1'b0;
			wen_o <= 1'b0;
			ebreak_o <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			id_valid_o <= if_valid_i;
			if (if_valid_i) begin
				br_op_o <= br_op;
				load_o <= load;
				store_o <= store;
				wen_o <= wen;
				ebreak_o <= ebreak;
				invalid_o <= invalid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (if_valid_i) begin
			pc_o <= pc_i;
			op_a_o <= sel_pc ? pc_i : rdata1_i;
			op_b_o <= rdata2_i;
			imm_o <= imm;
			use_imm_o <= use_imm;
			alu_op_o <= alu_op;
			rd_o <= inst_i[11:7];
		end
	end

endmodule

`default_nettype wire

/* src/rv_exu.sv */
`default_nettype none

module rv_exu import rv_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic id_valid_i,
	input wire word_t pc_i,
	input wire word_t op_a_i,
	input wire word_t op_b_i,
	input wire word_t imm_i,
	input wire logic use_imm_i,
	input wire alu_op_e alu_op_i,
	input wire br_op_e br_op_i,
	input wire logic load_i,
	input wire logic store_i,
	input wire logic wen_i,
	input wire reg_addr_t rd_i,
	input wire logic ebreak_i,
	input wire logic invalid_i,
	output logic ex_valid_o,
	output word_t result_o,
	output word_t store_data_o,
	output logic load_o,
	output logic store_o,
	output logic wen_o,
	output reg_addr_t rd_o,
	output logic ebreak_o,
	output logic invalid_o,
	output logic redirect_o,
	output word_t redirect_pc_o
);

	word_t alu_b, alu_res, target;
	logic [4:0] shamt;
	logic taken, is_jump;

	assign alu_b = use_imm_i ? imm_i : op_b_i;
	assign shamt = alu_b[4:0];
	assign is_jump = (br_op_i == br_jal) || (br_op_i == br_jalr);

	always_comb begin
		case (alu_op_i)
			alu_sub: alu_res = op_a_i - alu_b;
			alu_sll: alu_res = op_a_i << shamt;
			alu_slt: alu_res = {31'b0, $signed(op_a_i) < $signed(alu_b)};
			alu_sltu: alu_res = {31'b0, op_a_i < alu_b};
			alu_xor: alu_res = op_a_i ^ alu_b;
			alu_srl: alu_res = op_a_i >> shamt;
			alu_sra: alu_res = word_t'($signed(op_a_i) >>> shamt);
			alu_or: alu_res = op_a_i | alu_b;
			alu_and: alu_res = op_a_i & alu_b;
			alu_pass_b: alu_res = alu_b;
			default: alu_res = op_a_i + alu_b;
		endcase
	end

	// branches compare the two register operands
	always_comb begin
		case (br_op_i)
			br_eq: taken = (op_a_i == op_b_i);
			br_ne: taken = (op_a_i != op_b_i);
			br_lt: taken = $signed(op_a_i) < $signed(op_b_i);
			br_ge: taken = $signed(op_a_i) >= $signed(op_b_i);
			br_ltu: taken = op_a_i < op_b_i;
			br_geu: taken = op_a_i >= op_b_i;
			br_jal, br_jalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// jalr target has bit 0 cleared
	assign target = (br_op_i == br_jalr) ? ((op_a_i + imm_i) & ~32'd1) : pc_i + imm_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_valid_o <= 1'b0;
			load_o <= 1'b0;
			store_o <= 1'b0;
			wen_o <= 1'b0;
			ebreak_o <= 1'b0;
			invalid_o <= 1'b0;
			redirect_o <= 1'b0;
		end else begin
			ex_valid_o <= id_valid_i;
			if (id_valid_i) begin
				load_o <= load_i;
				store_o <= store_i;
				wen_o <= wen_i;
				ebreak_o <= ebreak_i;
				invalid_o <= invalid_i;
				redirect_o <= taken;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (id_valid_i) begin
			// link value for jumps
			result_o <= is_jump ? pc_i + 32'd4 : alu_res;
			store_data_o <= op_b_i;
			rd_o <= rd_i;
			redirect_pc_o <= target;
		end
	end

endmodule

`default_nettype wire

/* src/rv_ifu.sv */
`default_nettype none

module rv_ifu import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0
) (
	input wire logic clk,
	input wire logic reset_i,
	output word_t imem_addr_o,
	input wire word_t imem_data_i,
	input wire logic retire_i,
	input wire logic redirect_i,
	input wire word_t redirect_pc_i,
	input wire logic halt_i,
	output word_t pc_o,
	output word_t inst_o,
	output logic if_valid_o
);

	typedef enum logic [1:0] {
		st_fetch,
		st_wait,
		st_halted
	} ifu_state_e;

	ifu_state_e state_q;
	word_t pc_q;
	word_t inst_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= st_fetch;
			pc_q <= RESET_PC;
			if_valid_o <= 1'b0;
		end else begin
			// strobe lasts one cycle
			if_valid_o <= 1'b0;
			case (state_q)
				st_fetch: begin
					if_valid_o <= 1'b1;
					state_q <= st_wait;
				end
				st_wait: begin
					if (retire_i) begin
						if (halt_i) begin
							// pc stays on the stopping instruction
							state_q <= st_halted;
						end else begin
							pc_q <= redirect_i ? redirect_pc_i : pc_q + 32'd4;
							state_q <= st_fetch;
						end
					end
				end
				default: state_q <= st_halted;
			endcase
		end
	end

	// instruction word held until the next fetch
	always_ff @(posedge clk) begin
		if (state_q == st_fetch) begin
			inst_q <= imem_data_i;
		end
	end

	assign imem_addr_o = pc_q;
	assign pc_o = pc_q;
	assign inst_o = inst_q;

endmodule

`default_nettype wire

/* src/rv_lsu.sv */
`default_nettype none

module rv_lsu import rv_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic ex_valid_i,
	input wire word_t result_i,
	input wire word_t store_data_i,
	input wire logic load_i,
	input wire logic store_i,
	input wire logic wen_i,
	input wire reg_addr_t rd_i,
	input wire logic ebreak_i,
	input wire logic invalid_i,
	output word_t dmem_addr_o,
	output word_t dmem_wdata_o,
	output logic dmem_wen_o,
	input wire word_t dmem_rdata_i,
	output logic ls_valid_o,
	output word_t wdata_o,
	output logic wen_o,
	output reg_addr_t rd_o,
	output logic ebreak_o,
	output logic invalid_o
);

	// address comes straight from the alu
	assign dmem_addr_o = result_i;
	assign dmem_wdata_o = store_data_i;
	assign dmem_wen_o = ex_valid_i & store_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ls_valid_o <= 1'b0;
			wen_o <= 1'b0;
			ebreak_o <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			ls_valid_o <= ex_valid_i;
			if (ex_valid_i) begin
				wen_o <= wen_i;
				ebreak_o <= ebreak_i;
				invalid_o <= invalid_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid_i) begin
			wdata_o <= load_i ? dmem_rdata_i : result_i;
			rd_o <= rd_i;
		end
	end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// data, address and instruction word
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [3:0] {
		br_none,
		br_eq,
		br_ne,
		br_lt,
		br_ge,
		br_ltu,
		br_geu,
		br_jal,
		br_jalr
	} br_op_e;

	// major opcodes of rv32i
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire reg_addr_t raddr1_i,
	input wire reg_addr_t raddr2_i,
	output word_t rdata1_o,
	output word_t rdata2_o,
	input wire logic wen_i,
	input wire reg_addr_t waddr_i,
	input wire word_t wdata_i
);

	word_t regs_q [1:31];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wen_i && waddr_i != 5'd0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// x0 always reads zero
	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* src/rv_wbu.sv */
`default_nettype none

module rv_wbu import rv_pkg::*; (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic ls_valid_i,
	input wire word_t wdata_i,
	input wire logic wen_i,
	input wire reg_addr_t rd_i,
	input wire logic ebreak_i,
	input wire logic invalid_i,
	output logic reg_wen_o,
	output reg_addr_t reg_waddr_o,
	output word_t reg_wdata_o,
	output logic retire_o,
	output logic finish_o,
	output logic invalid_o,
	output logic halt_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			finish_o <= 1'b0;
			invalid_o <= 1'b0;
		end else if (ls_valid_i) begin
			// sticky until reset
			finish_o <= finish_o | ebreak_i;
			invalid_o <= invalid_o | invalid_i;
		end
	end

	assign reg_wen_o = ls_valid_i & wen_i;
	assign reg_waddr_o = rd_i;
	assign reg_wdata_o = wdata_i;
	assign retire_o = ls_valid_i;

	// also covers the retiring instruction so the pc freezes on it
	assign halt_o = finish_o | invalid_o | (ls_valid_i & (ebreak_i | invalid_i));

endmodule

`default_nettype wire
